// ==== pi_bus_pkg.sv ====
// ==============================
// PI-bus wire-level package
// address, data, opcode and
// acknowledge encodings
// ==============================
`default_nettype none

package pi_bus_pkg;

   // word address, top two bits select the slave
   typedef logic [29:0] addr_t;

   typedef logic [31:0] data_t;

   typedef logic [3:0] opc_t;

   typedef logic [2:0] ack_t;

   // opcodes
   localparam opc_t OPC_NOP  = 4'h0;   // no transfer
   localparam opc_t OPC_WORD = 4'h1;   // single word

   // slave acknowledge codes
   localparam ack_t ACK_NON = 3'b000;  // nobody answers
   localparam ack_t ACK_WAT = 3'b001;  // insert wait
   localparam ack_t ACK_RDY = 3'b010;  // data valid, done
   localparam ack_t ACK_ERR = 3'b011;  // bus error

endpackage

`default_nettype wire

// ==== pi_agent_pkg.sv ====
// ==============================
// PI-bus agent package
// command response status codes
// ==============================
`default_nettype none

package pi_agent_pkg;

   typedef logic [1:0] status_t;

   localparam status_t ST_OK   = 2'd0;   // RDY seen
   localparam status_t ST_ERR  = 2'd1;   // ERR from slave
   localparam status_t ST_TOUT = 2'd2;   // controller timed out

endpackage

`default_nettype wire

// ==== pi_bus_ctrl.sv ====
// ==============================
// PI-bus controller
// round-robin arbiter with lock,
// bus mux, select and timeout
// ==============================
`timescale 1ns/1ps
`default_nettype none

module pi_bus_ctrl
   import pi_bus_pkg::*;
#(
   parameter int TOUT_LIMIT = 16
)
(
   input  logic  clk,
   input  logic  rst_n,

   input  logic  req0,
   input  logic  req1,
   input  addr_t addr0,
   input  addr_t addr1,
   input  opc_t  opc0,
   input  opc_t  opc1,
   input  logic  read0,
   input  logic  read1,
   input  logic  lock0,
   input  logic  lock1,
   input  data_t wdata0,
   input  data_t wdata1,
   input  ack_t  ack,

   output logic  gnt0,
   output logic  gnt1,
   output logic  owner,
   output addr_t bus_addr,
   output opc_t  bus_opc,
   output logic  bus_read,
   output data_t bus_wdata,
   output logic  sel,
   output logic  tout
);

   localparam int TCNT_W = $clog2(TOUT_LIMIT + 1);

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_REQ,
      BUS_ADDR,
      BUS_DATA
   } bus_state_t;

   bus_state_t        state;
   logic [TCNT_W-1:0] tout_cnt;
   logic              lock_hold;      // bus parked for a locked owner

   logic              in_xfer;
   logic              ack_end;
   logic              xfer_end;
   logic              req_own;
   logic              req_oth;
   logic              lock_own;
   logic              hold;
   logic              win_valid;
   logic              win_owner;
   logic              grant;

   // owner's fields onto the shared bus
   assign bus_addr  = owner ? addr1  : addr0;
   assign bus_opc   = owner ? opc1   : opc0;
   assign bus_read  = owner ? read1  : read0;
   assign bus_wdata = owner ? wdata1 : wdata0;

   // single slave lives where both top address bits are one
   assign sel = (bus_opc != OPC_NOP) && (bus_addr[29:28] == 2'b11);

   assign in_xfer  = (state == BUS_ADDR) || (state == BUS_DATA);
   assign ack_end  = (ack == ACK_RDY) || (ack == ACK_ERR);
   assign tout     = in_xfer && !ack_end && (tout_cnt == TCNT_W'(TOUT_LIMIT - 1));
   assign xfer_end = in_xfer && (ack_end || tout);

   // requests seen from the current owner's point of view
   assign req_own  = owner ? req1  : req0;
   assign req_oth  = owner ? req0  : req1;
   assign lock_own = owner ? lock1 : lock0;

   // in idle the parked lock counts, at the end of a transfer the live one
   assign hold = (state == BUS_IDLE) ? lock_hold : lock_own;

   // other master first, unless the owner keeps the bus locked
   assign win_valid = hold ? req_own : (req_own || req_oth);
   assign win_owner = (!hold && req_oth) ? ~owner : owner;

   assign grant = win_valid && ((state == BUS_IDLE) || xfer_end);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         gnt0     <= 1'b0;
         gnt1     <= 1'b0;
         owner    <= 1'b1;           // so master 0 wins the first round
         tout_cnt <= '0;
      end
      else
      begin
         gnt0 <= 1'b0;                // gnt is a single pulse
         gnt1 <= 1'b0;
         if (grant)
         begin
            owner    <= win_owner;
            gnt0     <= ~win_owner;
            gnt1     <= win_owner;
            tout_cnt <= '0;
         end
         else if (in_xfer)
         begin
            tout_cnt <= tout_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= BUS_IDLE;
         lock_hold <= 1'b0;
      end
      else
      begin
         case (state)
            BUS_IDLE:
            begin
               if (grant)
               begin
                  state <= BUS_REQ;
               end
            end
            BUS_REQ:
            begin
               state <= BUS_ADDR;     // owner puts its fields out next
            end
            BUS_ADDR, BUS_DATA:
            begin
               if (xfer_end)
               begin
                  lock_hold <= lock_own;
                  state     <= grant ? BUS_REQ : BUS_IDLE;
               end
               else
               begin
                  state <= BUS_DATA;  // WAT or NON, keep waiting
               end
            end
            default:
            begin
               state <= BUS_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== pi_bus_master.sv ====
// ==============================
// PI-bus master agent
// one command in, one bus
// transfer, one response out
// ==============================
`timescale 1ns/1ps
`default_nettype none

module pi_bus_master
   import pi_bus_pkg::*;
   import pi_agent_pkg::*;
#(
   parameter int MASTER_ID = 0
)
(
   input  logic    clk,
   input  logic    rst_n,

   input  logic    cmd_valid,
   input  logic    cmd_read,
   input  logic    cmd_lock,
   input  addr_t   cmd_addr,
   input  data_t   cmd_wdata,
   output logic    cmd_ready,

   output logic    rsp_valid,
   output data_t   rsp_rdata,
   output status_t rsp_status,

   output logic    req,
   input  logic    gnt,
   input  logic    owner,
   output addr_t   addr,
   output opc_t    opc,
   output logic    read,
   output logic    lock,
   output data_t   wdata,
   input  ack_t    ack,
   input  data_t   rdata,
   input  logic    tout
);

   typedef enum logic [1:0] {
      M_IDLE,
      M_REQ,
      M_XFER,
      M_RSP
   } mst_state_t;

   mst_state_t state;
   addr_t      addr_q;
   data_t      wdata_q;
   logic       read_q;
   logic       lock_q;
   logic       mine;
   logic       done;

   assign cmd_ready = (state == M_IDLE);
   assign req       = (state == M_REQ);
   assign rsp_valid = (state == M_RSP);

   // transfer fields, opcode only while we own the bus
   assign addr  = addr_q;
   assign wdata = wdata_q;
   assign read  = read_q;
   assign opc   = (state == M_XFER) ? OPC_WORD : OPC_NOP;
   assign lock  = (state == M_XFER) && lock_q;

   assign mine = (owner == 1'(MASTER_ID));
   assign done = (state == M_XFER) && mine
                 && ((ack == ACK_RDY) || (ack == ACK_ERR) || tout);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= M_IDLE;
      end
      else
      begin
         case (state)
            M_IDLE:  if (cmd_valid) state <= M_REQ;
            M_REQ:   if (gnt) state <= M_XFER;
            M_XFER:  if (done) state <= M_RSP;
            default: state <= M_IDLE;    // M_RSP lasts one cycle
         endcase
      end
   end

   // command capture
   always_ff @(posedge clk)
   begin
      if (cmd_valid && cmd_ready)
      begin
         addr_q  <= cmd_addr;
         wdata_q <= cmd_wdata;
         read_q  <= cmd_read;
         lock_q  <= cmd_lock;
      end
   end

   // response capture, ack wins over a coincident timeout
   always_ff @(posedge clk)
   begin
      if (done)
      begin
         if (ack == ACK_RDY)
         begin
            rsp_status <= ST_OK;
            rsp_rdata  <= rdata;
         end
         else if (ack == ACK_ERR)
         begin
            rsp_status <= ST_ERR;
         end
         else
         begin
            rsp_status <= ST_TOUT;
         end
      end
   end

endmodule

`default_nettype wire

// ==== pi_mem_slave.sv ====
// ==============================
// PI-bus memory slave
// word memory with wait states
// and out-of-range error
// ==============================
`timescale 1ns/1ps
`default_nettype none

module pi_mem_slave
   import pi_bus_pkg::*;
#(
   parameter int WAIT_STATES = 2,
   parameter int DEPTH_LOG2  = 6
)
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  sel,
   input  addr_t bus_addr,
   input  opc_t  bus_opc,
   input  logic  bus_read,
   input  data_t bus_wdata,
   output ack_t  ack,
   output data_t rdata
);

   localparam int WCNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

   data_t             mem [2**DEPTH_LOG2];
   logic              sel_q;
   logic              busy;
   logic [WCNT_W-1:0] wcnt;
   logic              start;
   logic              last_wait;
   logic              respond;
   logic              ok;
   logic [DEPTH_LOG2-1:0] idx;

   assign start     = sel && !sel_q;
   assign last_wait = (wcnt == WCNT_W'(WAIT_STATES - 1));
   assign respond   = sel && ((start && (WAIT_STATES == 0)) || (busy && last_wait));

   // bits between the index and the select bits must be clear
   assign ok  = !(|bus_addr[27:DEPTH_LOG2]) && (bus_opc == OPC_WORD);
   assign idx = bus_addr[DEPTH_LOG2-1:0];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         sel_q <= 1'b0;
         busy  <= 1'b0;
         wcnt  <= '0;
         ack   <= ACK_NON;
      end
      else
      begin
         sel_q <= sel;
         if (!sel)
         begin
            busy <= 1'b0;             // transfer gone, drop any count
            ack  <= ACK_NON;
         end
         else if (respond)
         begin
            busy <= 1'b0;
            ack  <= ok ? ACK_RDY : ACK_ERR;
         end
         else if (start)
         begin
            busy <= 1'b1;
            wcnt <= '0;
            ack  <= ACK_WAT;
         end
         else if (busy)
         begin
            wcnt <= wcnt + 1'b1;
            ack  <= ACK_WAT;
         end
         else
         begin
            ack <= ACK_NON;           // answered, wait for sel to fall
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 2**DEPTH_LOG2; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (respond && ok && !bus_read)
      begin
         mem[idx] <= bus_wdata;      // lands with RDY
      end
   end

   always_ff @(posedge clk)
   begin
      if (respond && ok && bus_read)
      begin
         rdata <= mem[idx];
      end
   end

endmodule

`default_nettype wire

// ==== pi_bus_top.sv ====
// ==============================
// PI-bus subsystem top
// two masters, controller and
// one memory slave
// ==============================
`timescale 1ns/1ps
`default_nettype none

module pi_bus_top
   import pi_bus_pkg::*;
   import pi_agent_pkg::*;
#(
   parameter int TOUT_LIMIT  = 16,
   parameter int WAIT_STATES = 2,
   parameter int DEPTH_LOG2  = 6
)
(
   input  logic    clk,
   input  logic    rst_n,

   input  logic    cmd_valid0,
   input  logic    cmd_read0,
   input  logic    cmd_lock0,
   input  addr_t   cmd_addr0,
   input  data_t   cmd_wdata0,
   output logic    cmd_ready0,
   output logic    rsp_valid0,
   output data_t   rsp_rdata0,
   output status_t rsp_status0,

   input  logic    cmd_valid1,
   input  logic    cmd_read1,
   input  logic    cmd_lock1,
   input  addr_t   cmd_addr1,
   input  data_t   cmd_wdata1,
   output logic    cmd_ready1,
   output logic    rsp_valid1,
   output data_t   rsp_rdata1,
   output status_t rsp_status1
);

   logic  req0, req1, gnt0, gnt1;
   logic  read0, read1, lock0, lock1;
   addr_t addr0, addr1, bus_addr;
   opc_t  opc0, opc1, bus_opc;
   data_t wdata0, wdata1, bus_wdata, rdata;
   logic  owner, bus_read, sel, tout;
   ack_t  ack;

   pi_bus_master #(.MASTER_ID(0)) u_master0 (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid(cmd_valid0), .cmd_read(cmd_read0), .cmd_lock(cmd_lock0),
      .cmd_addr(cmd_addr0), .cmd_wdata(cmd_wdata0), .cmd_ready(cmd_ready0),
      .rsp_valid(rsp_valid0), .rsp_rdata(rsp_rdata0), .rsp_status(rsp_status0),
      .req(req0), .gnt(gnt0), .owner(owner),
      .addr(addr0), .opc(opc0), .read(read0), .lock(lock0), .wdata(wdata0),
      .ack(ack), .rdata(rdata), .tout(tout)
   );

   pi_bus_master #(.MASTER_ID(1)) u_master1 (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid(cmd_valid1), .cmd_read(cmd_read1), .cmd_lock(cmd_lock1),
      .cmd_addr(cmd_addr1), .cmd_wdata(cmd_wdata1), .cmd_ready(cmd_ready1),
      .rsp_valid(rsp_valid1), .rsp_rdata(rsp_rdata1), .rsp_status(rsp_status1),
      .req(req1), .gnt(gnt1), .owner(owner),
      .addr(addr1), .opc(opc1), .read(read1), .lock(lock1), .wdata(wdata1),
      .ack(ack), .rdata(rdata), .tout(tout)
   );

   pi_bus_ctrl #(.TOUT_LIMIT(TOUT_LIMIT)) u_ctrl (
      .clk(clk), .rst_n(rst_n),
      .req0(req0), .req1(req1), .addr0(addr0), .addr1(addr1),
      .opc0(opc0), .opc1(opc1), .read0(read0), .read1(read1),
      .lock0(lock0), .lock1(lock1), .wdata0(wdata0), .wdata1(wdata1),
      .ack(ack), .gnt0(gnt0), .gnt1(gnt1), .owner(owner),
      .bus_addr(bus_addr), .bus_opc(bus_opc), .bus_read(bus_read),
      .bus_wdata(bus_wdata), .sel(sel), .tout(tout)
   );

   pi_mem_slave #(.WAIT_STATES(WAIT_STATES), .DEPTH_LOG2(DEPTH_LOG2)) u_slave (
      .clk(clk), .rst_n(rst_n), .sel(sel),
      .bus_addr(bus_addr), .bus_opc(bus_opc), .bus_read(bus_read),
      .bus_wdata(bus_wdata), .ack(ack), .rdata(rdata)
   );

endmodule

`default_nettype wire

// ==== tb_pi_bus.sv ====
// ==============================
// PI-bus subsystem testbench
// directed and random commands
// checked against a memory model
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_pi_bus
   import pi_bus_pkg::*;
   import pi_agent_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int TOUT_LIMIT   = 16;
   localparam int WAIT_STATES  = 2;
   localparam int DEPTH_LOG2   = 6;
   localparam int N_RAND       = 100;        // random commands per master
   localparam int N_CMDS       = 2 * N_RAND + 16;
   localparam int CMD_CYCLES   = 4 * (TOUT_LIMIT + WAIT_STATES + 8);
   localparam int WDOG_CYCLES  = 10 + N_CMDS * CMD_CYCLES;
   localparam int DRAIN_CYCLES = CMD_CYCLES;  // last commands of both masters

   logic        clk;
   logic        rst_n;
   logic        cmd_valid0, cmd_read0, cmd_lock0, cmd_ready0, rsp_valid0;
   logic        cmd_valid1, cmd_read1, cmd_lock1, cmd_ready1, rsp_valid1;
   addr_t       cmd_addr0, cmd_addr1;
   data_t       cmd_wdata0, cmd_wdata1, rsp_rdata0, rsp_rdata1;
   status_t     rsp_status0, rsp_status1;

   data_t       model_mem [2**DEPTH_LOG2];
   logic [62:0] pend0 [$];                   // {read, addr, wdata}
   logic [62:0] pend1 [$];
   int          acc_cnt [2];
   int          rsp_cnt [2];
   status_t     last_status [2];
   data_t       last_rdata [2];
   string       test_name;
   logic [31:0] lcg_state;
   logic        gen_read [2][N_RAND];
   logic        gen_lock [2][N_RAND];
   addr_t       gen_addr [2][N_RAND];
   data_t       gen_wdata [2][N_RAND];
   int          gen_gap [2][N_RAND];

   pi_bus_top #(
      .TOUT_LIMIT(TOUT_LIMIT),
      .WAIT_STATES(WAIT_STATES),
      .DEPTH_LOG2(DEPTH_LOG2)
   ) UUT (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid0(cmd_valid0), .cmd_read0(cmd_read0), .cmd_lock0(cmd_lock0),
      .cmd_addr0(cmd_addr0), .cmd_wdata0(cmd_wdata0), .cmd_ready0(cmd_ready0),
      .rsp_valid0(rsp_valid0), .rsp_rdata0(rsp_rdata0), .rsp_status0(rsp_status0),
      .cmd_valid1(cmd_valid1), .cmd_read1(cmd_read1), .cmd_lock1(cmd_lock1),
      .cmd_addr1(cmd_addr1), .cmd_wdata1(cmd_wdata1), .cmd_ready1(cmd_ready1),
      .rsp_valid1(rsp_valid1), .rsp_rdata1(rsp_rdata1), .rsp_status1(rsp_status1)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(WDOG_CYCLES * CLK_PERIOD);
      $display("ERROR: watchdog expired before the tests finished");
      $display("Some tests failed");
      $fatal(1);
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // expected status from the address alone
   function automatic status_t status_for(input addr_t a);
      if (a[29:28] != 2'b11)
         return ST_TOUT;                     // no slave selected
      else if (|a[27:DEPTH_LOG2])
         return ST_ERR;
      else
         return ST_OK;
   endfunction

   function automatic addr_t mem_addr(input int idx);
      addr_t a;
      a = '0;
      a[29:28] = 2'b11;
      a[DEPTH_LOG2-1:0] = idx[DEPTH_LOG2-1:0];
      return a;
   endfunction

   // 1/8 select clear, 1/8 out of range, rest in range
   function automatic addr_t make_addr(input int m, input logic [31:0] r);
      addr_t a;
      a = r[29:0];
      if (r[31:29] == 3'd0)
      begin
         a[29:28] = 2'b00;
      end
      else
      begin
         a[29:28] = 2'b11;
         a[27:DEPTH_LOG2] = '0;
         if (r[31:29] == 3'd1)
            a[DEPTH_LOG2 + 2] = 1'b1;
         else if (m == 1)
            a[DEPTH_LOG2-1] = 1'b1;          // master 1 stays in the upper half
      end
      return a;
   endfunction

   task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
      if (expv !== actv)
      begin
         $display("CHECK FAILED %s expected %h actual %h", name, expv, actv);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   // starts 1 ns after a rising edge and ends 1 ns after the accepting edge
   task automatic send_cmd(input int m, input logic rd, input logic lk, input addr_t a,
                           input data_t wd);
      logic taken;
      taken = 1'b0;
      if (m == 0)
      begin
         cmd_valid0 = 1'b1;
         cmd_read0  = rd;
         cmd_lock0  = lk;
         cmd_addr0  = a;
         cmd_wdata0 = wd;
      end
      else
      begin
         cmd_valid1 = 1'b1;
         cmd_read1  = rd;
         cmd_lock1  = lk;
         cmd_addr1  = a;
         cmd_wdata1 = wd;
      end
      while (!taken)
      begin
         @(negedge clk);
         taken = (m == 0) ? cmd_ready0 : cmd_ready1;   // ready moves only on posedge
      end
      @(posedge clk);
      if (m == 0)
         pend0.push_back({rd, a, wd});
      else
         pend1.push_back({rd, a, wd});
      acc_cnt[m]++;
      #1;
      if (m == 0)
         cmd_valid0 = 1'b0;
      else
         cmd_valid1 = 1'b0;
   endtask

   task automatic do_cmd(input int m, input logic rd, input logic lk, input addr_t a,
                         input data_t wd);
      int target;
      target = rsp_cnt[m] + 1;
      send_cmd(m, rd, lk, a, wd);
      while (rsp_cnt[m] < target)
         @(posedge clk);
      #1;
   endtask

   task automatic score_rsp(input int m, input status_t st, input data_t rd);
      logic [62:0] ent;
      status_t     exp_st;
      int          idx;
      if ((m == 0) ? (pend0.size() == 0) : (pend1.size() == 0))
      begin
         $display("ERROR: master %0d responded with no command outstanding", m);
         $display("Some tests failed");
         $fatal(1);
      end
      else
      begin
         if (m == 0)
            ent = pend0.pop_front();
         else
            ent = pend1.pop_front();
         exp_st = status_for(ent[61:32]);
         idx    = ent[32 +: DEPTH_LOG2];
         compare({test_name, " status"}, exp_st, st);
         if (exp_st == ST_OK && ent[62])
            compare({test_name, " rdata"}, model_mem[idx], rd);
         else if (exp_st == ST_OK)
            model_mem[idx] = ent[31:0];      // writes apply in response order
         last_status[m] = st;
         last_rdata[m]  = rd;
         rsp_cnt[m]++;
      end
   endtask

   task automatic run_random(input int m);
      for (int i = 0; i < N_RAND; i++)
      begin
         if (gen_gap[m][i] != 0)
         begin
            repeat (gen_gap[m][i]) @(posedge clk);
            #1;
         end
         send_cmd(m, gen_read[m][i], gen_lock[m][i], gen_addr[m][i], gen_wdata[m][i]);
      end
   endtask

   // response monitor
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (rst_n && rsp_valid0 === 1'b1)
            score_rsp(0, rsp_status0, rsp_rdata0);
         if (rst_n && rsp_valid1 === 1'b1)
            score_rsp(1, rsp_status1, rsp_rdata1);
      end
   end

   initial
   begin
      int          base0;
      int          base1;
      int          wait_cnt;
      addr_t       a;
      logic [31:0] r;
      lcg_state  = 32'he034;
      test_name  = "reset";
      rst_n      = 1'b0;
      cmd_valid0 = 1'b0;
      cmd_read0  = 1'b0;
      cmd_lock0  = 1'b0;
      cmd_addr0  = '0;
      cmd_wdata0 = '0;
      cmd_valid1 = 1'b0;
      cmd_read1  = 1'b0;
      cmd_lock1  = 1'b0;
      cmd_addr1  = '0;
      cmd_wdata1 = '0;
      for (int i = 0; i < 2**DEPTH_LOG2; i++)
         model_mem[i] = '0;
      for (int m = 0; m < 2; m++)
      begin
         acc_cnt[m] = 0;
         rsp_cnt[m] = 0;
      end
      for (int i = 0; i < N_RAND; i++)
      begin
         for (int m = 0; m < 2; m++)
         begin
            r = next_rand();
            gen_read[m][i]  = r[0];
            gen_lock[m][i]  = (r[3:1] == 3'd0) && (i != N_RAND - 1);  // last one unlocks
            gen_gap[m][i]   = r[5:4];
            gen_addr[m][i]  = make_addr(m, next_rand());
            gen_wdata[m][i] = next_rand();
         end
      end

      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      compare("reset rsp_valid0", 0, rsp_valid0);
      compare("reset rsp_valid1", 0, rsp_valid1);
      compare("reset cmd_ready0", 1, cmd_ready0);
      compare("reset cmd_ready1", 1, cmd_ready1);
      @(posedge clk);
      #1;

      test_name = "write_read";
      do_cmd(0, 1'b0, 1'b0, mem_addr(5), 32'ha5a5_1234);
      compare("write_read wr status", ST_OK, last_status[0]);
      do_cmd(0, 1'b1, 1'b0, mem_addr(5), 32'h0);
      compare("write_read rd status", ST_OK, last_status[0]);
      compare("write_read rdata", 32'ha5a5_1234, last_rdata[0]);

      test_name = "range_error";
      a = mem_addr(5);
      a[DEPTH_LOG2 + 3] = 1'b1;
      do_cmd(0, 1'b0, 1'b0, a, 32'hdead_beef);
      compare("range_error status", ST_ERR, last_status[0]);
      do_cmd(0, 1'b1, 1'b0, mem_addr(5), 32'h0);
      compare("range_error next status", ST_OK, last_status[0]);
      compare("range_error next rdata", 32'ha5a5_1234, last_rdata[0]);

      test_name = "timeout";
      a = mem_addr(7);
      a[29:28] = 2'b00;
      do_cmd(0, 1'b0, 1'b0, a, 32'h1111_2222);
      compare("timeout status", ST_TOUT, last_status[0]);
      do_cmd(1, 1'b0, 1'b0, mem_addr(40), 32'h3333_4444);
      compare("timeout next status", ST_OK, last_status[1]);

      test_name = "random";
      base0 = acc_cnt[0];
      base1 = acc_cnt[1];
      fork
         run_random(0);
         run_random(1);
      join
      wait_cnt = 0;
      while ((rsp_cnt[0] != acc_cnt[0] || rsp_cnt[1] != acc_cnt[1])
             && wait_cnt < DRAIN_CYCLES)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      #1;
      compare("random responses m0", base0 + N_RAND, rsp_cnt[0]);
      compare("random responses m1", base1 + N_RAND, rsp_cnt[1]);

      // master 1 must wait until master 0 drops lock
      test_name = "lock_hold";
      base0 = acc_cnt[0];
      base1 = rsp_cnt[1];
      fork
         begin
            for (int i = 0; i < 4; i++)
               do_cmd(0, 1'b0, 1'b1, mem_addr(i), 32'h1000 + i);
            do_cmd(0, 1'b0, 1'b0, mem_addr(4), 32'h2000);
         end
         begin
            while (acc_cnt[0] == base0)
               @(negedge clk);
            @(posedge clk);
            #1;
            do_cmd(1, 1'b1, 1'b0, mem_addr(33), 32'h0);
         end
         begin
            while (rsp_cnt[1] == base1)
               @(posedge clk);
            compare("lock_hold order", base0 + 5, acc_cnt[0]);
         end
      join

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
pi_bus_pkg.sv
pi_agent_pkg.sv
pi_bus_ctrl.sv
pi_bus_master.sv
pi_mem_slave.sv
pi_bus_top.sv
tb_pi_bus.sv

// ==== Bender.yml ====
package:
  name: pi_bus

sources:
  - pi_bus_pkg.sv
  - pi_agent_pkg.sv
  - pi_bus_ctrl.sv
  - pi_bus_master.sv
  - pi_mem_slave.sv
  - pi_bus_top.sv
  - target: simulation
    files:
      - tb_pi_bus.sv
